//--- source/cachePkg.sv
// cache geometry, coherence state, address union, port request and response structs
package cachePkg;

	// address split
	localparam int tagWidth    = 6;
	localparam int indexWidth  = 4;
	localparam int offsetWidth = 2;
	localparam int addrWidth   = tagWidth + indexWidth + offsetWidth;

	// associativity and line geometry
	localparam int wayBits      = 2;
	localparam int numWays      = 1 << wayBits;
	localparam int numSets      = 1 << indexWidth;
	localparam int wordsPerLine = 1 << offsetWidth;
	localparam int dataWidth    = 16;

	// coherence state with invalid held at zero
	typedef enum logic [1:0] {
		stateInvalid   = 2'd0,
		stateShared    = 2'd1,
		stateExclusive = 2'd2,
		stateModified  = 2'd3
	} lineStateE;

	typedef struct packed {
		logic [tagWidth-1:0]    tag;
		logic [indexWidth-1:0]  index;
		logic [offsetWidth-1:0] offset;
	} addrFieldsT;

	// same bus word seen flat or split into fields
	typedef union packed {
		logic [addrWidth-1:0] raw;
		addrFieldsT           fields;
	} cacheAddrU;

	typedef struct packed {
		cacheAddrU              addr;
		logic [dataWidth-1:0]   dataIn;
		lineStateE              stateIn;
		logic                   writeTag;
		logic                   writeData;
		logic                   writeState;
	} cpuReqT;

	typedef struct packed {
		logic                   hit;
		logic [wayBits-1:0]     way;
		logic [tagWidth-1:0]    tagOut;
		logic [dataWidth-1:0]   dataOut;
		lineStateE              stateOut;
	} cpuRespT;

	typedef struct packed {
		cacheAddrU              addr;
		lineStateE              stateIn;
		logic                   writeState;
	} snoopReqT;

	typedef struct packed {
		logic                   hit;
		logic [wayBits-1:0]     way;
		logic [dataWidth-1:0]   dataOut;
		lineStateE              stateOut;
	} snoopRespT;

	// what a single way returns for one port
	typedef struct packed {
		logic                   hit;
		logic [tagWidth-1:0]    tagOut;
		logic [dataWidth-1:0]   dataOut;
		lineStateE              stateOut;
	} wayLookupT;

endpackage

//--- source/directMappedWay.sv
// one cache way with tag, state and data storage and two lookup ports
module directMappedWay (
	input  logic                clock,
	input  logic                rstN,
	input  cachePkg::cpuReqT    cpuReq,
	input  logic                cpuWriteTag,
	input  logic                cpuWriteData,
	input  logic                cpuWriteState,
	input  cachePkg::snoopReqT  snoopReq,
	input  logic                snoopWriteState,
	output cachePkg::wayLookupT cpuLookup,
	output cachePkg::wayLookupT snoopLookup
);

	// per set storage
	logic [cachePkg::tagWidth-1:0]  tagMem   [cachePkg::numSets];
	cachePkg::lineStateE            stateMem [cachePkg::numSets];
	logic [cachePkg::dataWidth-1:0] dataMem  [cachePkg::numSets][cachePkg::wordsPerLine];

	logic [cachePkg::indexWidth-1:0]  cpuIndex;
	logic [cachePkg::offsetWidth-1:0] cpuOffset;
	logic [cachePkg::indexWidth-1:0]  snoopIndex;
	logic [cachePkg::offsetWidth-1:0] snoopOffset;

	assign cpuIndex    = cpuReq.addr.fields.index;
	assign cpuOffset   = cpuReq.addr.fields.offset;
	assign snoopIndex  = snoopReq.addr.fields.index;
	assign snoopOffset = snoopReq.addr.fields.offset;

	// read one set for one port
	function automatic cachePkg::wayLookupT lookup(
		input logic [cachePkg::indexWidth-1:0]  index,
		input logic [cachePkg::offsetWidth-1:0] offset,
		input logic [cachePkg::tagWidth-1:0]    tag
	);
		cachePkg::wayLookupT result;
		result.tagOut   = tagMem[index];
		result.dataOut  = dataMem[index][offset];
		result.stateOut = stateMem[index];
		// invalid lines never hit, whatever the stale tag holds
		result.hit      = (tagMem[index] == tag) &&
			(stateMem[index] != cachePkg::stateInvalid);
		return result;
	endfunction

	always_comb begin
		cpuLookup   = lookup(cpuIndex, cpuOffset, cpuReq.addr.fields.tag);
		snoopLookup = lookup(snoopIndex, snoopOffset, snoopReq.addr.fields.tag);
	end

	// tag and data payload
	always_ff @(posedge clock) begin
		if (cpuWriteTag) begin
			tagMem[cpuIndex] <= cpuReq.addr.fields.tag;
		end
		if (cpuWriteData) begin
			dataMem[cpuIndex][cpuOffset] <= cpuReq.dataIn;
		end
	end

	// cpu state write comes last so it wins on the same set
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < cachePkg::numSets; s++) begin
				stateMem[s] <= cachePkg::stateInvalid;
			end
		end else begin
			if (snoopWriteState) begin
				stateMem[snoopIndex] <= snoopReq.stateIn;
			end
			if (cpuWriteState) begin
				stateMem[cpuIndex] <= cpuReq.stateIn;
			end
		end
	end

	// a colliding snoop write is only harmless when it agrees with the cpu
	snoopWriteLost: assert property (@(posedge clock) disable iff (!rstN)
		!(cpuWriteState && snoopWriteState && (cpuIndex == snoopIndex) &&
			(cpuReq.stateIn != snoopReq.stateIn)))
		else $error("snoop state write to set %0d lost to cpu write", snoopIndex);

endmodule

//--- source/lruReplacement.sv
// per set age counters, access and invalidate updates, victim selection
module lruReplacement (
	input  logic                            clock,
	input  logic                            rstN,
	input  logic                            accessEnable,
	input  logic [cachePkg::indexWidth-1:0] accessIndex,
	input  logic [cachePkg::wayBits-1:0]    accessWay,
	input  logic                            invalidateEnable,
	input  logic [cachePkg::indexWidth-1:0] invalidateIndex,
	input  logic [cachePkg::wayBits-1:0]    invalidateWay,
	input  logic [cachePkg::indexWidth-1:0] victimIndex,
	output logic [cachePkg::wayBits-1:0]    victimWay
);

	// one age per way where the oldest is all ones
	typedef logic [cachePkg::numWays-1:0][cachePkg::wayBits-1:0] ageRowT;

	ageRowT ages [cachePkg::numSets];
	ageRowT accessRow;
	ageRowT invalidateRow;
	logic [cachePkg::numWays-1:0] victimMask;

	// accessed way becomes youngest
	function automatic ageRowT promote(input ageRowT row, input logic [cachePkg::wayBits-1:0] way);
		ageRowT next;
		next = row;
		for (int w = 0; w < cachePkg::numWays; w++) begin
			if (w == way) begin
				next[w] = '0;
			end else if (row[w] < row[way]) begin
				next[w] = row[w] + 1'b1;
			end
		end
		return next;
	endfunction

	// invalidated way becomes oldest
	function automatic ageRowT demote(input ageRowT row, input logic [cachePkg::wayBits-1:0] way);
		ageRowT next;
		next = row;
		for (int w = 0; w < cachePkg::numWays; w++) begin
			if (w == way) begin
				next[w] = '1;
			end else if (row[w] > row[way]) begin
				next[w] = row[w] - 1'b1;
			end
		end
		return next;
	endfunction

	function automatic logic [cachePkg::numWays-1:0] oldestMask(input ageRowT row);
		logic [cachePkg::numWays-1:0] mask;
		for (int w = 0; w < cachePkg::numWays; w++) begin
			mask[w] = &row[w];
		end
		return mask;
	endfunction

	// invalidation sees the access result when both hit one set
	always_comb begin
		accessRow = promote(ages[accessIndex], accessWay);
		if (accessEnable && (accessIndex == invalidateIndex)) begin
			invalidateRow = demote(accessRow, invalidateWay);
		end else begin
			invalidateRow = demote(ages[invalidateIndex], invalidateWay);
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int s = 0; s < cachePkg::numSets; s++) begin
				for (int w = 0; w < cachePkg::numWays; w++) begin
					ages[s][w] <= w[cachePkg::wayBits-1:0];
				end
			end
		end else begin
			if (accessEnable) begin
				ages[accessIndex] <= accessRow;
			end
			if (invalidateEnable) begin
				ages[invalidateIndex] <= invalidateRow;
			end
		end
	end

	always_comb begin
		victimMask = oldestMask(ages[victimIndex]);
		victimWay  = '0;
		for (int w = 0; w < cachePkg::numWays; w++) begin
			if (victimMask[w]) begin
				victimWay = w[cachePkg::wayBits-1:0];
			end
		end
	end

	// ages must stay a permutation with a single oldest way
	accessKeepsOneOldest: assert property (@(posedge clock) disable iff (!rstN)
		accessEnable |=> $onehot(oldestMask(ages[$past(accessIndex)])))
		else $error("set %0d lost its single oldest way after access", $past(accessIndex));

	invalidateKeepsOneOldest: assert property (@(posedge clock) disable iff (!rstN)
		invalidateEnable |=> $onehot(oldestMask(ages[$past(invalidateIndex)])))
		else $error("set %0d lost its single oldest way after invalidate",
			$past(invalidateIndex));

endmodule

//--- source/setAssociativeCacheUnit.sv
// four way cache array with cpu and snoop ports and lru replacement
module setAssociativeCacheUnit (
	input  logic                clock,
	input  logic                rstN,
	input  cachePkg::cpuReqT    cpuReq,
	input  cachePkg::snoopReqT  snoopReq,
	input  logic                accessEnable,
	input  logic                invalidateEnable,
	output cachePkg::cpuRespT   cpuResp,
	output cachePkg::snoopRespT snoopResp
);

	cachePkg::wayLookupT cpuLookup   [cachePkg::numWays];
	cachePkg::wayLookupT snoopLookup [cachePkg::numWays];

	logic [cachePkg::numWays-1:0] cpuHits;
	logic [cachePkg::numWays-1:0] snoopHits;
	logic                         cpuHit;
	logic                         snoopHit;

	logic [cachePkg::wayBits-1:0] victimWay;
	logic [cachePkg::numWays-1:0] victimSelect;
	logic [cachePkg::numWays-1:0] cpuSelect;
	logic [cachePkg::wayBits-1:0] cpuWay;
	logic [cachePkg::wayBits-1:0] snoopWay;

	// steered write strobes
	logic [cachePkg::numWays-1:0] cpuWriteTag;
	logic [cachePkg::numWays-1:0] cpuWriteData;
	logic [cachePkg::numWays-1:0] cpuWriteState;
	logic [cachePkg::numWays-1:0] snoopWriteState;

	for (genvar w = 0; w < cachePkg::numWays; w++) begin : wayGen
		directMappedWay wayInst (
			.clock           (clock),
			.rstN            (rstN),
			.cpuReq          (cpuReq),
			.cpuWriteTag     (cpuWriteTag[w]),
			.cpuWriteData    (cpuWriteData[w]),
			.cpuWriteState   (cpuWriteState[w]),
			.snoopReq        (snoopReq),
			.snoopWriteState (snoopWriteState[w]),
			.cpuLookup       (cpuLookup[w]),
			.snoopLookup     (snoopLookup[w])
		);

		assign cpuHits[w]   = cpuLookup[w].hit;
		assign snoopHits[w] = snoopLookup[w].hit;
	end

	lruReplacement lru (
		.clock            (clock),
		.rstN             (rstN),
		.accessEnable     (accessEnable),
		.accessIndex      (cpuReq.addr.fields.index),
		.accessWay        (cpuResp.way),
		.invalidateEnable (invalidateEnable),
		.invalidateIndex  (snoopReq.addr.fields.index),
		.invalidateWay    (snoopResp.way),
		.victimIndex      (cpuReq.addr.fields.index),
		.victimWay        (victimWay)
	);

	assign cpuHit   = |cpuHits;
	assign snoopHit = |snoopHits;

	// victim number to one hot
	always_comb begin
		for (int w = 0; w < cachePkg::numWays; w++) begin
			victimSelect[w] = (victimWay == w[cachePkg::wayBits-1:0]);
		end
	end

	// cpu falls back to the victim on a miss while snoop only touches a hit
	assign cpuSelect = cpuHit ? cpuHits : victimSelect;

	assign cpuWriteTag     = {cachePkg::numWays{cpuReq.writeTag}} & cpuSelect;
	assign cpuWriteData    = {cachePkg::numWays{cpuReq.writeData}} & cpuSelect;
	assign cpuWriteState   = {cachePkg::numWays{cpuReq.writeState}} & cpuSelect;
	assign snoopWriteState = {cachePkg::numWays{snoopReq.writeState}} & snoopHits;

	// one hot to way number
	always_comb begin
		cpuWay   = '0;
		snoopWay = '0;
		for (int w = 0; w < cachePkg::numWays; w++) begin
			if (cpuSelect[w]) begin
				cpuWay = w[cachePkg::wayBits-1:0];
			end
			if (snoopHits[w]) begin
				snoopWay = w[cachePkg::wayBits-1:0];
			end
		end
	end

	// on a miss this shows the line that would be evicted
	always_comb begin
		cpuResp.hit      = cpuHit;
		cpuResp.way      = cpuWay;
		cpuResp.tagOut   = cpuLookup[cpuWay].tagOut;
		cpuResp.dataOut  = cpuLookup[cpuWay].dataOut;
		cpuResp.stateOut = cpuLookup[cpuWay].stateOut;
	end

	always_comb begin
		snoopResp.hit      = snoopHit;
		snoopResp.way      = snoopWay;
		snoopResp.dataOut  = '0;
		snoopResp.stateOut = cachePkg::stateInvalid;
		if (snoopHit) begin
			snoopResp.dataOut  = snoopLookup[snoopWay].dataOut;
			snoopResp.stateOut = snoopLookup[snoopWay].stateOut;
		end
	end

	// a tag may live in one way of a set only
	cpuSingleHit: assert property (@(posedge clock) disable iff (!rstN)
		$onehot0(cpuHits))
		else $error("cpu address hits in several ways: %b", cpuHits);

	snoopSingleHit: assert property (@(posedge clock) disable iff (!rstN)
		$onehot0(snoopHits))
		else $error("snoop address hits in several ways: %b", snoopHits);

	// lru update needs a resolved way select
	accessWayKnown: assert property (@(posedge clock) disable iff (!rstN)
		accessEnable |-> !$isunknown(cpuSelect))
		else $error("accessEnable with unknown cpu way");

endmodule

//--- test/cacheVectors.svh
// stimulus and expected response rows for the cache array testbench
// columns are name, cpu addr, cpu state, strobes tag data state, snoop addr, snoop state,
// snoop write, pulses access invalidate, cpu hit way state data check, snoop hit way state
addRow("reset both miss", 'h144, sInv, 'b000, 'h144, sInv, 0, 'b00, 0, 3, sInv, 0, 0, 0, sInv);
addRow("reset last set", 'habc, sInv, 'b000, 'hfff, sInv, 0, 'b00, 0, 3, sInv, 0, 0, 0, sInv);
// set 1, one line written at two offsets
addRow("fill set1 word0", 'h144, sExc, 'b111, 'hfff, sInv, 0, 'b10, 0, 3, sInv, 0, 0, 0, sInv);
addRow("write set1 word1", 'h145, sInv, 'b010, 'hfff, sInv, 0, 'b10, 1, 3, sExc, 0, 0, 0, sInv);
addRow("read set1 word0", 'h144, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
addRow("read set1 word1", 'h145, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
addRow("set1 other tag", 'h184, sInv, 'b000, 'hfff, sInv, 0, 'b00, 0, 2, sInv, 0, 0, 0, sInv);
// set 2 fills ways 3 2 1 0, then the fifth tag takes way 3 again
addRow("fill A", 'h408, sMod, 'b111, 'hfff, sInv, 0, 'b10, 0, 3, sInv, 0, 0, 0, sInv);
addRow("fill B", 'h448, sShr, 'b111, 'hfff, sInv, 0, 'b10, 0, 2, sInv, 0, 0, 0, sInv);
addRow("fill C", 'h488, sExc, 'b111, 'hfff, sInv, 0, 'b10, 0, 1, sInv, 0, 0, 0, sInv);
addRow("fill D", 'h4c8, sShr, 'b111, 'hfff, sInv, 0, 'b10, 0, 0, sInv, 0, 0, 0, sInv);
addRow("fill E evicts A", 'h508, sExc, 'b111, 'hfff, sInv, 0, 'b10, 0, 3, sMod, 0, 0, 0, sInv);
addRow("A evicted", 'h408, sInv, 'b000, 'hfff, sInv, 0, 'b00, 0, 2, sShr, 0, 0, 0, sInv);
addRow("B hits", 'h448, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 2, sShr, 1, 0, 0, sInv);
addRow("C hits", 'h488, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 1, sExc, 1, 0, 0, sInv);
addRow("D hits", 'h4c8, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 0, sShr, 1, 0, 0, sInv);
addRow("E hits", 'h508, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
// touching B leaves C as the oldest
addRow("reaccess B", 'h448, sInv, 'b000, 'hfff, sInv, 0, 'b10, 1, 2, sShr, 1, 0, 0, sInv);
addRow("fill F evicts C", 'h548, sShr, 'b111, 'hfff, sInv, 0, 'b10, 0, 1, sExc, 0, 0, 0, sInv);
addRow("C evicted", 'h488, sInv, 'b000, 'hfff, sInv, 0, 'b00, 0, 0, sShr, 0, 0, 0, sInv);
addRow("B survives", 'h448, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 2, sShr, 1, 0, 0, sInv);
// set 3, snoop state writes and invalidation
addRow("fill set3 mod", 'h80c, sMod, 'b111, 'hfff, sInv, 0, 'b10, 0, 3, sInv, 0, 0, 0, sInv);
addRow("snoop sees mod", 'h80c, sInv, 'b000, 'h80c, sInv, 0, 'b00, 1, 3, sMod, 1, 1, 3, sMod);
addRow("snoop to shared", 'h80c, sInv, 'b000, 'h80c, sShr, 1, 'b00, 1, 3, sMod, 1, 1, 3, sMod);
addRow("both see shared", 'h80c, sInv, 'b000, 'h80c, sInv, 0, 'b00, 1, 3, sShr, 1, 1, 3, sShr);
addRow("snoop miss write", 'h80c, sInv, 'b000, 'h84c, sInv, 1, 'b00, 1, 3, sShr, 1, 0, 0, sInv);
addRow("line unchanged", 'h80c, sInv, 'b000, 'h80c, sInv, 0, 'b00, 1, 3, sShr, 1, 1, 3, sShr);
addRow("snoop invalidate", 'h80c, sInv, 'b000, 'h80c, sInv, 1, 'b01, 1, 3, sShr, 1, 1, 3, sShr);
addRow("invalid misses", 'h80c, sInv, 'b000, 'h80c, sInv, 0, 'b00, 0, 3, sInv, 0, 0, 0, sInv);
addRow("refill way3", 'h8cc, sExc, 'b111, 'hfff, sInv, 0, 'b10, 0, 3, sInv, 0, 0, 0, sInv);
addRow("refill hits", 'h8cc, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
// other sets left alone by all of the above
addRow("set1 word0 kept", 'h144, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
addRow("set1 word1 kept", 'h145, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 3, sExc, 1, 0, 0, sInv);
addRow("set1 victim kept", 'h184, sInv, 'b000, 'hfff, sInv, 0, 'b00, 0, 2, sInv, 0, 0, 0, sInv);
addRow("set2 victim kept", 'h588, sInv, 'b000, 'h448, sInv, 0, 'b00, 0, 0, sShr, 0, 1, 2, sShr);
addRow("D still hits", 'h4c8, sInv, 'b000, 'hfff, sInv, 0, 'b00, 1, 0, sShr, 1, 0, 0, sInv);

//--- test/cacheTb.sv
// cache array testbench top with clock, reset, vector loop, response checks and watchdog
module cacheTb;

	localparam int clockPeriod  = 8;
	localparam int resetCycles  = 5;
	localparam int marginCycles = 20;

	// short state names for the vector table
	localparam cachePkg::lineStateE sInv = cachePkg::stateInvalid;
	localparam cachePkg::lineStateE sShr = cachePkg::stateShared;
	localparam cachePkg::lineStateE sExc = cachePkg::stateExclusive;
	localparam cachePkg::lineStateE sMod = cachePkg::stateModified;

	typedef struct packed {
		logic [cachePkg::addrWidth-1:0] cpuAddr;
		cachePkg::lineStateE            cpuState;
		logic [2:0]                     cpuStrobes;
		logic [cachePkg::addrWidth-1:0] snoopAddr;
		cachePkg::lineStateE            snoopState;
		logic                           snoopWrite;
		logic [1:0]                     pulses;
		logic                           expCpuHit;
		logic [cachePkg::wayBits-1:0]   expCpuWay;
		cachePkg::lineStateE            expCpuState;
		logic                           checkData;
		logic                           expSnoopHit;
		logic [cachePkg::wayBits-1:0]   expSnoopWay;
		cachePkg::lineStateE            expSnoopState;
	} vectorT;

	logic                clock;
	logic                rstN;
	cachePkg::cpuReqT    cpuReq;
	cachePkg::snoopReqT  snoopReq;
	logic                accessEnable;
	logic                invalidateEnable;
	cachePkg::cpuRespT   cpuResp;
	cachePkg::snoopRespT snoopResp;

	vectorT vectors [$];
	string  vectorNames [$];
	bit     tableReady = 1'b0;
	// last word written at each flat address
	logic [cachePkg::dataWidth-1:0] shadow [1 << cachePkg::addrWidth];
	// last tag written into each set and way
	logic [cachePkg::tagWidth-1:0]  tagShadow [cachePkg::numSets][cachePkg::numWays];

	setAssociativeCacheUnit dut0 (
		.clock            (clock),
		.rstN             (rstN),
		.cpuReq           (cpuReq),
		.snoopReq         (snoopReq),
		.accessEnable     (accessEnable),
		.invalidateEnable (invalidateEnable),
		.cpuResp          (cpuResp),
		.snoopResp        (snoopResp)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	task automatic addRow(
		input string                          name,
		input logic [cachePkg::addrWidth-1:0] cpuAddr,
		input cachePkg::lineStateE            cpuState,
		input logic [2:0]                     cpuStrobes,
		input logic [cachePkg::addrWidth-1:0] snoopAddr,
		input cachePkg::lineStateE            snoopState,
		input logic                           snoopWrite,
		input logic [1:0]                     pulses,
		input logic                           expCpuHit,
		input logic [cachePkg::wayBits-1:0]   expCpuWay,
		input cachePkg::lineStateE            expCpuState,
		input logic                           checkData,
		input logic                           expSnoopHit,
		input logic [cachePkg::wayBits-1:0]   expSnoopWay,
		input cachePkg::lineStateE            expSnoopState
	);
		vectors.push_back(vectorT'{cpuAddr, cpuState, cpuStrobes, snoopAddr, snoopState,
			snoopWrite, pulses, expCpuHit, expCpuWay, expCpuState, checkData, expSnoopHit,
			expSnoopWay, expSnoopState});
		vectorNames.push_back(name);
	endtask

	task automatic loadTable();
		`include "cacheVectors.svh"
	endtask

	task automatic checkValue(input string testName, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s %s expected %0h actual %0h", testName, field, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	initial begin : watchdog
		wait (tableReady);
		#((vectors.size() + resetCycles + marginCycles) * clockPeriod);
		$display("timeout, the vector table did not finish in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	initial begin : mainFlow
		vectorT                          v;
		string                           name;
		logic [31:0]                     randWord;
		logic [cachePkg::dataWidth-1:0]  wordIn;
		logic [cachePkg::dataWidth-1:0]  snoopData;
		logic [cachePkg::indexWidth-1:0] setIndex;
		logic [cachePkg::tagWidth-1:0]   addrTag;
		rstN             = 1'b0;
		cpuReq           = '0;
		snoopReq         = '0;
		accessEnable     = 1'b0;
		invalidateEnable = 1'b0;
		void'($urandom(32'hc6a6_2eab));
		loadTable();
		tableReady = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		for (int r = 0; r < vectors.size(); r++) begin
			v        = vectors[r];
			name     = vectorNames[r];
			setIndex = v.cpuAddr[cachePkg::offsetWidth +: cachePkg::indexWidth];
			addrTag  = v.cpuAddr[cachePkg::addrWidth-1 -: cachePkg::tagWidth];
			@(negedge clock);
			randWord = $urandom;
			wordIn   = randWord[cachePkg::dataWidth-1:0];
			cpuReq.addr.raw     = v.cpuAddr;
			cpuReq.dataIn       = wordIn;
			cpuReq.stateIn      = v.cpuState;
			{cpuReq.writeTag, cpuReq.writeData, cpuReq.writeState} = v.cpuStrobes;
			snoopReq.addr.raw   = v.snoopAddr;
			snoopReq.stateIn    = v.snoopState;
			snoopReq.writeState = v.snoopWrite;
			{accessEnable, invalidateEnable} = v.pulses;
			// sample just before the write edge
			#(clockPeriod / 2 - 1);
			checkValue(name, "cpu hit", v.expCpuHit, cpuResp.hit);
			checkValue(name, "cpu way", v.expCpuWay, cpuResp.way);
			checkValue(name, "cpu state", v.expCpuState, cpuResp.stateOut);
			if (v.expCpuHit) begin
				checkValue(name, "cpu tag", addrTag, cpuResp.tagOut);
			end else if (!$isunknown(tagShadow[setIndex][v.expCpuWay])) begin
				// a miss shows the tag of the line it would evict
				checkValue(name, "victim tag", tagShadow[setIndex][v.expCpuWay],
					cpuResp.tagOut);
			end
			if (v.checkData) begin
				checkValue(name, "cpu data", shadow[v.cpuAddr], cpuResp.dataOut);
			end
			// snoop miss reads back as zero
			snoopData = v.expSnoopHit ? shadow[v.snoopAddr] : '0;
			checkValue(name, "snoop hit", v.expSnoopHit, snoopResp.hit);
			checkValue(name, "snoop way", v.expSnoopWay, snoopResp.way);
			checkValue(name, "snoop state", v.expSnoopState, snoopResp.stateOut);
			checkValue(name, "snoop data", snoopData, snoopResp.dataOut);
			if (v.cpuStrobes[2]) begin
				tagShadow[setIndex][v.expCpuWay] = addrTag;
			end
			if (v.cpuStrobes[1]) begin
				shadow[v.cpuAddr] = wordIn;
			end
		end

		@(negedge clock);
		cpuReq           = '0;
		snoopReq         = '0;
		accessEnable     = 1'b0;
		invalidateEnable = 1'b0;
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- sources.f
+incdir+test
source/cachePkg.sv
source/directMappedWay.sv
source/lruReplacement.sv
source/setAssociativeCacheUnit.sv
test/cacheTb.sv

//--- Bender.yml
package:
  name: cache_array

sources:
  - source/cachePkg.sv
  - source/directMappedWay.sv
  - source/lruReplacement.sv
  - source/setAssociativeCacheUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cacheTb.sv
